// ==== design/cache_data_mem.sv ====
// two-way data array with per-way write enable and registered read
`timescale 1ns/1ps
`default_nettype none

module cache_data_mem (
  input  wire                      clk_i,
  input  wire                      v_i,
  input  wire                      w_i,
  input  wire                      way_i,
  input  dma_cfg_pkg::mem_addr_t   addr_i,
  input  dma_cfg_pkg::way_row_t    data_i,
  output dma_cfg_pkg::way_row_t    data_o
);

  // one word array per way
  dma_cfg_pkg::word_t way0_r [dma_cfg_pkg::rows];
  dma_cfg_pkg::word_t way1_r [dma_cfg_pkg::rows];

  dma_cfg_pkg::way_row_t data_r;

  logic wr_en;
  logic rd_en;

  assign wr_en = v_i & w_i;
  assign rd_en = v_i & ~w_i;

  always_ff @(posedge clk_i) begin
    if (wr_en && !way_i) begin
      way0_r[addr_i] <= data_i[dma_cfg_pkg::data_width-1:0];
    end
    if (wr_en && way_i) begin
      way1_r[addr_i] <= data_i[2*dma_cfg_pkg::data_width-1:dma_cfg_pkg::data_width];
    end
  end

  // output keeps the last read until the next one
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      data_r <= {way1_r[addr_i], way0_r[addr_i]};
    end
  end

  assign data_o = data_r;

endmodule

`default_nettype wire

// ==== design/cache_dma_ctrl.sv ====
// DMA controller FSM for address packets, block fill, block eviction and snoop word
`timescale 1ns/1ps
`default_nettype none

module cache_dma_ctrl (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      send_fill_addr_i,
  input  wire                      send_evict_addr_i,
  input  wire                      get_fill_data_i,
  input  wire                      send_evict_data_i,
  input  wire                      way_i,
  input  dma_cfg_pkg::addr_t       addr_i,
  input  dma_cfg_pkg::count_t      count_i,
  input  wire                      fill_v_i,
  input  dma_cfg_pkg::word_t       fill_data_i,
  input  wire                      evict_ready_i,
  input  dma_cfg_pkg::way_row_t    mem_row_i,
  input  wire                      pkt_yumi_i,
  output logic                     done_o,
  output dma_cfg_pkg::word_t       snoop_word_o,
  output dma_msg_pkg::dma_pkt_t    pkt_o,
  output logic                     pkt_v_o,
  output logic                     count_set_o,
  output logic                     count_en_o,
  output dma_cfg_pkg::count_t      count_val_o,
  output logic                     fill_yumi_o,
  output logic                     evict_v_o,
  output dma_cfg_pkg::word_t       evict_data_o,
  output logic                     mem_v_o,
  output logic                     mem_w_o,
  output logic                     mem_way_o,
  output dma_cfg_pkg::mem_addr_t   mem_addr_o,
  output dma_cfg_pkg::way_row_t    mem_data_o
);

  dma_msg_pkg::dma_state_e state_r;
  dma_msg_pkg::dma_state_e state_n;

  logic [dma_cfg_pkg::set_width-1:0] set_idx;
  dma_cfg_pkg::word_off_t            snoop_off;
  dma_cfg_pkg::word_off_t            row_off;
  logic                              fill_last;
  logic                              evict_last;
  logic                              snoop_we;

  assign set_idx   = addr_i[dma_cfg_pkg::block_off_width +: dma_cfg_pkg::set_width];
  assign snoop_off = addr_i[dma_cfg_pkg::byte_off_width +: dma_cfg_pkg::word_off_width];

  assign fill_last  = (count_i == dma_cfg_pkg::count_t'(dma_cfg_pkg::block_words - 1));
  assign evict_last = (count_i == dma_cfg_pkg::count_t'(dma_cfg_pkg::block_words));

  // word 0 is read straight from IDLE before the counter loads
  assign row_off    = (state_r == dma_msg_pkg::IDLE) ? '0 :
                      count_i[dma_cfg_pkg::word_off_width-1:0];
  assign mem_addr_o = {set_idx, row_off};
  assign mem_way_o  = way_i;
  assign mem_data_o = {2{fill_data_i}};

  assign evict_data_o = way_i ? mem_row_i[2*dma_cfg_pkg::data_width-1:dma_cfg_pkg::data_width]
                              : mem_row_i[dma_cfg_pkg::data_width-1:0];

  // block-aligned address below write_not_read
  assign pkt_o = {state_r == dma_msg_pkg::SEND_EVICT_ADDR,
                  addr_i[dma_cfg_pkg::addr_width-1:dma_cfg_pkg::block_off_width],
                  {dma_cfg_pkg::block_off_width{1'b0}}};

  always_comb begin
    state_n     = state_r;
    done_o      = 1'b0;
    pkt_v_o     = 1'b0;
    count_set_o = 1'b0;
    count_en_o  = 1'b0;
    count_val_o = '0;
    fill_yumi_o = 1'b0;
    evict_v_o   = 1'b0;
    mem_v_o     = 1'b0;
    mem_w_o     = 1'b0;

    case (state_r)
      dma_msg_pkg::IDLE: begin
        if (send_fill_addr_i) begin
          state_n = dma_msg_pkg::SEND_FILL_ADDR;
        end else if (send_evict_addr_i) begin
          state_n = dma_msg_pkg::SEND_EVICT_ADDR;
        end else if (get_fill_data_i) begin
          state_n     = dma_msg_pkg::GET_FILL_DATA;
          count_set_o = 1'b1;
        end else if (send_evict_data_i) begin
          state_n     = dma_msg_pkg::SEND_EVICT_DATA;
          count_set_o = 1'b1;
          count_val_o = dma_cfg_pkg::count_t'(1);
          mem_v_o     = 1'b1;
        end
      end

      dma_msg_pkg::SEND_FILL_ADDR,
      dma_msg_pkg::SEND_EVICT_ADDR: begin
        pkt_v_o = 1'b1;
        done_o  = pkt_yumi_i;
        if (pkt_yumi_i) begin
          state_n = dma_msg_pkg::IDLE;
        end
      end

      dma_msg_pkg::GET_FILL_DATA: begin
        mem_v_o     = fill_v_i;
        mem_w_o     = fill_v_i;
        fill_yumi_o = fill_v_i;
        count_en_o  = fill_v_i & ~fill_last;
        count_set_o = fill_v_i & fill_last;
        done_o      = fill_v_i & fill_last;
        if (fill_v_i && fill_last) begin
          state_n = dma_msg_pkg::IDLE;
        end
      end

      dma_msg_pkg::SEND_EVICT_DATA: begin
        // push the row read last time, then read the next one
        evict_v_o   = evict_ready_i;
        mem_v_o     = evict_ready_i & ~evict_last;
        count_en_o  = evict_ready_i & ~evict_last;
        count_set_o = evict_ready_i & evict_last;
        done_o      = evict_ready_i & evict_last;
        if (evict_ready_i && evict_last) begin
          state_n = dma_msg_pkg::IDLE;
        end
      end

      default: begin
        state_n = dma_msg_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= dma_msg_pkg::IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  assign snoop_we = (state_r == dma_msg_pkg::GET_FILL_DATA) & fill_v_i
    & (count_i[dma_cfg_pkg::word_off_width-1:0] == snoop_off);

  always_ff @(posedge clk_i) begin
    if (snoop_we) begin
      snoop_word_o <= fill_data_i;
    end
  end

  // miss handler raises one command at a time
  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == dma_msg_pkg::IDLE) |->
      $onehot0({send_fill_addr_i, send_evict_addr_i, get_fill_data_i, send_evict_data_i}))
    else $error("more than one DMA command raised");

endmodule

`default_nettype wire

// ==== design/cache_dma_top.sv ====
// refill and writeback engine top with controller, counter, buffers and data array
`timescale 1ns/1ps
`default_nettype none

module cache_dma_top (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      send_fill_addr_i,
  input  wire                      send_evict_addr_i,
  input  wire                      get_fill_data_i,
  input  wire                      send_evict_data_i,
  input  dma_cfg_pkg::addr_t       addr_i,
  input  wire                      way_i,
  output logic                     done_o,
  output dma_cfg_pkg::word_t       snoop_word_o,
  output dma_msg_pkg::dma_pkt_t    dma_pkt_o,
  output logic                     dma_pkt_v_o,
  input  wire                      dma_pkt_yumi_i,
  input  dma_cfg_pkg::word_t       dma_data_i,
  input  wire                      dma_data_v_i,
  output logic                     dma_data_ready_o,
  output dma_cfg_pkg::word_t       dma_data_o,
  output logic                     dma_data_v_o,
  input  wire                      dma_data_yumi_i
);

  logic                    count_set;
  logic                    count_en;
  dma_cfg_pkg::count_t     count_val;
  dma_cfg_pkg::count_t     count;
  logic                    fill_v;
  dma_cfg_pkg::word_t      fill_data;
  logic                    fill_yumi;
  logic                    evict_v;
  dma_cfg_pkg::word_t      evict_data;
  logic                    evict_ready;
  logic                    mem_v;
  logic                    mem_w;
  logic                    mem_way;
  dma_cfg_pkg::mem_addr_t  mem_addr;
  dma_cfg_pkg::way_row_t   mem_wdata;
  dma_cfg_pkg::way_row_t   mem_rdata;

  cache_dma_ctrl u_ctrl (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .send_fill_addr_i(send_fill_addr_i),
    .send_evict_addr_i(send_evict_addr_i),
    .get_fill_data_i(get_fill_data_i),
    .send_evict_data_i(send_evict_data_i),
    .way_i(way_i),
    .addr_i(addr_i),
    .count_i(count),
    .fill_v_i(fill_v),
    .fill_data_i(fill_data),
    .evict_ready_i(evict_ready),
    .mem_row_i(mem_rdata),
    .pkt_yumi_i(dma_pkt_yumi_i),
    .done_o(done_o),
    .snoop_word_o(snoop_word_o),
    .pkt_o(dma_pkt_o),
    .pkt_v_o(dma_pkt_v_o),
    .count_set_o(count_set),
    .count_en_o(count_en),
    .count_val_o(count_val),
    .fill_yumi_o(fill_yumi),
    .evict_v_o(evict_v),
    .evict_data_o(evict_data),
    .mem_v_o(mem_v),
    .mem_w_o(mem_w),
    .mem_way_o(mem_way),
    .mem_addr_o(mem_addr),
    .mem_data_o(mem_wdata)
  );

  dma_word_counter u_counter (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .set_i(count_set),
    .en_i(count_en),
    .val_i(count_val),
    .count_o(count)
  );

  dma_fill_fifo u_fill_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i(dma_data_i),
    .v_i(dma_data_v_i),
    .ready_o(dma_data_ready_o),
    .v_o(fill_v),
    .data_o(fill_data),
    .yumi_i(fill_yumi)
  );

  dma_evict_buffer u_evict_buffer (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i(evict_data),
    .v_i(evict_v),
    .ready_o(evict_ready),
    .v_o(dma_data_v_o),
    .data_o(dma_data_o),
    .yumi_i(dma_data_yumi_i)
  );

  cache_data_mem u_data_mem (
    .clk_i(clk_i),
    .v_i(mem_v),
    .w_i(mem_w),
    .way_i(mem_way),
    .addr_i(mem_addr),
    .data_i(mem_wdata),
    .data_o(mem_rdata)
  );

endmodule

`default_nettype wire

// ==== design/dma_cfg_pkg.sv ====
// cache geometry constants and vector types for addresses, words, rows and counts
`default_nettype none

package dma_cfg_pkg;

  localparam int addr_width  = 32;
  localparam int data_width  = 32;
  localparam int block_words = 8;
  localparam int sets        = 16;

  // derived field widths
  localparam int byte_off_width  = $clog2(data_width / 8);
  localparam int word_off_width  = $clog2(block_words);
  localparam int set_width       = $clog2(sets);
  localparam int block_off_width = byte_off_width + word_off_width;
  localparam int count_width     = $clog2(block_words + 1);

  // rows in the data array, one per word of every set
  localparam int rows = sets * block_words;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] word_t;

  // way 1 sits in the upper word
  typedef logic [2*data_width-1:0] way_row_t;

  // set index above word offset
  typedef logic [set_width+word_off_width-1:0] mem_addr_t;

  typedef logic [word_off_width-1:0] word_off_t;
  typedef logic [count_width-1:0] count_t;

endpackage

`default_nettype wire

// ==== design/dma_evict_buffer.sv ====
// two-entry buffer between data array reads and the outgoing word stream
`timescale 1ns/1ps
`default_nettype none

module dma_evict_buffer (
  input  wire                  clk_i,
  input  wire                  reset_i,
  input  dma_cfg_pkg::word_t   data_i,
  input  wire                  v_i,
  output logic                 ready_o,
  output logic                 v_o,
  output dma_cfg_pkg::word_t   data_o,
  input  wire                  yumi_i
);

  dma_cfg_pkg::word_t head_r;
  dma_cfg_pkg::word_t tail_r;
  logic               head_v_r;
  logic               tail_v_r;

  assign ready_o = ~tail_v_r;
  assign v_o     = head_v_r;
  assign data_o  = head_r;

  // occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_v_r <= 1'b0;
      tail_v_r <= 1'b0;
    end else if (yumi_i) begin
      head_v_r <= tail_v_r | v_i;
      tail_v_r <= tail_v_r & v_i;
    end else if (v_i) begin
      head_v_r <= 1'b1;
      tail_v_r <= head_v_r;
    end
  end

  // tail moves up on a pop, otherwise new words land in the first free slot
  always_ff @(posedge clk_i) begin
    if (yumi_i) begin
      head_r <= tail_v_r ? tail_r : data_i;
      tail_r <= data_i;
    end else if (v_i) begin
      if (head_v_r) begin
        tail_r <= data_i;
      end else begin
        head_r <= data_i;
      end
    end
  end

  // the controller checks ready before each push
  assert property (@(posedge clk_i) disable iff (reset_i) v_i |-> ready_o)
    else $error("evict buffer pushed while full");

endmodule

`default_nettype wire

// ==== design/dma_fill_fifo.sv ====
// block-deep circular FIFO holding incoming fill words
`timescale 1ns/1ps
`default_nettype none

module dma_fill_fifo (
  input  wire                  clk_i,
  input  wire                  reset_i,
  input  dma_cfg_pkg::word_t   data_i,
  input  wire                  v_i,
  output logic                 ready_o,
  output logic                 v_o,
  output dma_cfg_pkg::word_t   data_o,
  input  wire                  yumi_i
);

  // pointers carry a wrap bit above the index
  logic [dma_cfg_pkg::word_off_width:0] wptr_r;
  logic [dma_cfg_pkg::word_off_width:0] rptr_r;

  dma_cfg_pkg::word_t mem_r [dma_cfg_pkg::block_words];

  logic empty;
  logic full;
  logic push;
  logic pop;

  assign empty = (wptr_r == rptr_r);
  assign full  = (wptr_r[dma_cfg_pkg::word_off_width] != rptr_r[dma_cfg_pkg::word_off_width])
    && (wptr_r[dma_cfg_pkg::word_off_width-1:0] == rptr_r[dma_cfg_pkg::word_off_width-1:0]);

  assign ready_o = ~full;
  assign v_o     = ~empty;
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;
  assign data_o  = mem_r[rptr_r[dma_cfg_pkg::word_off_width-1:0]];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
    end else begin
      if (push) begin
        wptr_r <= wptr_r + 1'b1;
      end
      if (pop) begin
        rptr_r <= rptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r[dma_cfg_pkg::word_off_width-1:0]] <= data_i;
    end
  end

  // controller only pops a word it can see
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
    else $error("fill FIFO popped while empty");

  // memory side never sends more than one block ahead
  assert property (@(posedge clk_i) disable iff (reset_i) v_i |-> ready_o)
    else $error("fill FIFO pushed while full");

endmodule

`default_nettype wire

// ==== design/dma_msg_pkg.sv ====
// DMA packet layout and the controller state encoding
`default_nettype none

package dma_msg_pkg;

  // write_not_read on top of the block address
  localparam int dma_pkt_width = dma_cfg_pkg::addr_width + 1;

  typedef logic [dma_pkt_width-1:0] dma_pkt_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    SEND_FILL_ADDR,
    SEND_EVICT_ADDR,
    GET_FILL_DATA,
    SEND_EVICT_DATA
  } dma_state_e;

endpackage

`default_nettype wire

// ==== design/dma_word_counter.sv ====
// loadable word counter used to walk through a cache block
`timescale 1ns/1ps
`default_nettype none

module dma_word_counter (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   set_i,
  input  wire                   en_i,
  input  dma_cfg_pkg::count_t   val_i,
  output dma_cfg_pkg::count_t   count_o
);

  dma_cfg_pkg::count_t count_r;

  // load wins over increment
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (set_i) begin
      count_r <= val_i;
    end else if (en_i) begin
      count_r <= count_r + dma_cfg_pkg::count_t'(1);
    end
  end

  assign count_o = count_r;

  // eviction stops at block_words, fill one short of it
  assert property (@(posedge clk_i) disable iff (reset_i)
    count_r <= dma_cfg_pkg::count_t'(dma_cfg_pkg::block_words))
    else $error("word counter ran past the block");

endmodule

`default_nettype wire

// ==== test/cache_dma_tb.sv ====
// testbench for the cache DMA engine with memory-side driver, reference model and monitor
`timescale 1ns/1ps
`default_nettype none

module cache_dma_tb;

  localparam int clk_period   = 100;
  localparam int drive_delay  = 10;
  localparam int reset_cycles = 16;
  localparam int block_bytes  = dma_cfg_pkg::block_words * (dma_cfg_pkg::data_width / 8);

  // reference result kinds
  localparam int kind_read_pkt  = 0;
  localparam int kind_write_pkt = 1;
  localparam int kind_evict     = 2;
  localparam int kind_snoop     = 3;

  localparam int cmd_fill_addr  = 0;
  localparam int cmd_evict_addr = 1;
  localparam int cmd_fill_data  = 2;
  localparam int cmd_evict_data = 3;

  // 16 address, 8 fill/evict, 4 way isolation, 8 snoop, 16 back-pressure operations
  localparam int num_ops    = 52;
  localparam int op_cycles  = 4 * dma_cfg_pkg::block_words + 16;
  localparam int max_cycles = 10 * (num_ops * op_cycles + reset_cycles);

  logic                  clk_i;
  logic                  reset_i;
  logic                  send_fill_addr_i;
  logic                  send_evict_addr_i;
  logic                  get_fill_data_i;
  logic                  send_evict_data_i;
  dma_cfg_pkg::addr_t    addr_i;
  logic                  way_i;
  logic                  done_o;
  dma_cfg_pkg::word_t    snoop_word_o;
  dma_msg_pkg::dma_pkt_t dma_pkt_o;
  logic                  dma_pkt_v_o;
  logic                  dma_pkt_yumi_i;
  dma_cfg_pkg::word_t    dma_data_i;
  logic                  dma_data_v_i;
  logic                  dma_data_ready_o;
  dma_cfg_pkg::word_t    dma_data_o;
  logic                  dma_data_v_o;
  logic                  dma_data_yumi_i;

  // model of the data array, sets by ways by words
  dma_cfg_pkg::word_t model_mem [dma_cfg_pkg::sets][2][dma_cfg_pkg::block_words];

  logic [63:0]        exp_pkt_q [$];
  logic [63:0]        exp_word_q [$];
  dma_cfg_pkg::word_t fill_q [$];

  string test_name = "reset";
  logic  stall_on = 1'b0;
  int    cmd_cnt = 0;
  int    done_cnt = 0;
  int    cycle_cnt = 0;

  cache_dma_top u_cache_dma_top (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .send_fill_addr_i(send_fill_addr_i),
    .send_evict_addr_i(send_evict_addr_i),
    .get_fill_data_i(get_fill_data_i),
    .send_evict_data_i(send_evict_data_i),
    .addr_i(addr_i),
    .way_i(way_i),
    .done_o(done_o),
    .snoop_word_o(snoop_word_o),
    .dma_pkt_o(dma_pkt_o),
    .dma_pkt_v_o(dma_pkt_v_o),
    .dma_pkt_yumi_i(dma_pkt_yumi_i),
    .dma_data_i(dma_data_i),
    .dma_data_v_i(dma_data_v_i),
    .dma_data_ready_o(dma_data_ready_o),
    .dma_data_o(dma_data_o),
    .dma_data_v_o(dma_data_v_o),
    .dma_data_yumi_i(dma_data_yumi_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s during %s", what, test_name);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // expected packet, evicted word or snoop word
  function automatic logic [63:0] ref_model(input int kind, input dma_cfg_pkg::addr_t addr,
                                            input logic way, input int off);
    int          set_idx;
    int          word_off;
    logic [63:0] result;
    set_idx  = (addr / block_bytes) % dma_cfg_pkg::sets;
    word_off = (addr / (dma_cfg_pkg::data_width / 8)) % dma_cfg_pkg::block_words;
    case (kind)
      kind_read_pkt:  result = {1'b0, addr & ~dma_cfg_pkg::addr_t'(block_bytes - 1)};
      kind_write_pkt: result = {1'b1, addr & ~dma_cfg_pkg::addr_t'(block_bytes - 1)};
      kind_evict:     result = model_mem[set_idx][way][off];
      default:        result = model_mem[set_idx][way][word_off];
    endcase
    return result;
  endfunction

  function automatic logic should_stall();
    return stall_on && ($urandom_range(0, 2) == 0);
  endfunction

  // memory side: fill words, packet yumi and outgoing data yumi
  initial begin
    dma_pkt_yumi_i  = 1'b0;
    dma_data_i      = '0;
    dma_data_v_i    = 1'b0;
    dma_data_yumi_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (dma_data_v_i && dma_data_ready_o) begin
        void'(fill_q.pop_front());
      end
      #drive_delay;
      if (fill_q.size() > 0 && !should_stall()) begin
        dma_data_v_i = 1'b1;
        dma_data_i   = fill_q[0];
      end else begin
        dma_data_v_i = 1'b0;
        dma_data_i   = '0;
      end
      dma_pkt_yumi_i  = dma_pkt_v_o && !should_stall();
      dma_data_yumi_i = dma_data_v_o && !should_stall();
    end
  end

  // compares accepted packets and words against the expected queues
  initial begin
    forever begin
      @(posedge clk_i);
      if (!reset_i) begin
        if (done_o) begin
          done_cnt++;
        end
        if (dma_pkt_v_o && dma_pkt_yumi_i) begin
          if (exp_pkt_q.size() == 0) begin
            report_failure("a packet arrived that was not expected");
          end else begin
            check_value({test_name, " packet"}, exp_pkt_q.pop_front(), 64'(dma_pkt_o));
          end
        end
        if (dma_data_v_o && dma_data_yumi_i) begin
          if (exp_word_q.size() == 0) begin
            report_failure("an outgoing word arrived that was not expected");
          end else begin
            check_value({test_name, " word"}, exp_word_q.pop_front(), 64'(dma_data_o));
          end
        end
      end
    end
  end

  initial begin
    while (cycle_cnt < max_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

  task automatic run_command(input int cmd, input dma_cfg_pkg::addr_t addr, input logic way);
    addr_i            = addr;
    way_i             = way;
    send_fill_addr_i  = (cmd == cmd_fill_addr);
    send_evict_addr_i = (cmd == cmd_evict_addr);
    get_fill_data_i   = (cmd == cmd_fill_data);
    send_evict_data_i = (cmd == cmd_evict_data);
    cmd_cnt++;
    do begin
      @(posedge clk_i);
    end while (!done_o);
    #drive_delay;
    send_fill_addr_i  = 1'b0;
    send_evict_addr_i = 1'b0;
    get_fill_data_i   = 1'b0;
    send_evict_data_i = 1'b0;
  endtask

  task automatic send_address(input logic write, input dma_cfg_pkg::addr_t addr,
                              input logic way);
    exp_pkt_q.push_back(ref_model(write ? kind_write_pkt : kind_read_pkt, addr, way, 0));
    run_command(write ? cmd_evict_addr : cmd_fill_addr, addr, way);
  endtask

  task automatic fill_block(input dma_cfg_pkg::addr_t addr, input logic way);
    int                 set_idx;
    dma_cfg_pkg::word_t word;
    set_idx = (addr / block_bytes) % dma_cfg_pkg::sets;
    for (int w = 0; w < dma_cfg_pkg::block_words; w++) begin
      word = $urandom;
      model_mem[set_idx][way][w] = word;
      fill_q.push_back(word);
    end
    run_command(cmd_fill_data, addr, way);
    check_value({test_name, " snoop"}, ref_model(kind_snoop, addr, way, 0), 64'(snoop_word_o));
  endtask

  task automatic evict_block(input dma_cfg_pkg::addr_t addr, input logic way);
    for (int w = 0; w < dma_cfg_pkg::block_words; w++) begin
      exp_word_q.push_back(ref_model(kind_evict, addr, way, w));
    end
    run_command(cmd_evict_data, addr, way);
  endtask

  // wait for outstanding traffic, then the ports must be quiet
  task automatic drain_and_check();
    while (exp_pkt_q.size() != 0 || exp_word_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
    #drive_delay;
    check_value({test_name, " pkt_v idle"}, 64'(0), 64'(dma_pkt_v_o));
    check_value({test_name, " data_v idle"}, 64'(0), 64'(dma_data_v_o));
    check_value({test_name, " done count"}, 64'(cmd_cnt), 64'(done_cnt));
  endtask

  initial begin
    dma_cfg_pkg::addr_t addr;
    logic               way;
    void'($urandom(32'h4e287157));
    reset_i           = 1'b1;
    send_fill_addr_i  = 1'b0;
    send_evict_addr_i = 1'b0;
    get_fill_data_i   = 1'b0;
    send_evict_data_i = 1'b0;
    addr_i            = '0;
    way_i             = 1'b0;
    repeat (reset_cycles) @(posedge clk_i);
    #drive_delay;
    reset_i = 1'b0;
    check_value("reset done", 64'(0), 64'(done_o));
    check_value("reset pkt_v", 64'(0), 64'(dma_pkt_v_o));
    check_value("reset data_v", 64'(0), 64'(dma_data_v_o));
    check_value("reset ready", 64'(1), 64'(dma_data_ready_o));

    test_name = "addr_pkt";
    stall_on  = 1'b1;
    for (int i = 0; i < 16; i++) begin
      addr = $urandom;
      way  = 1'($urandom_range(0, 1));
      send_address(1'(i % 2), addr, way);
    end
    drain_and_check();

    test_name = "fill_evict";
    stall_on  = 1'b0;
    for (int i = 0; i < 4; i++) begin
      addr = $urandom;
      way  = 1'($urandom_range(0, 1));
      fill_block(addr, way);
      evict_block(addr, way);
    end
    drain_and_check();

    test_name = "way_isolation";
    addr = $urandom;
    fill_block(addr, 1'b0);
    fill_block(addr, 1'b1);
    evict_block(addr, 1'b0);
    evict_block(addr, 1'b1);
    drain_and_check();

    // one fill per word offset
    test_name = "snoop";
    for (int off = 0; off < dma_cfg_pkg::block_words; off++) begin
      addr = ($urandom & ~32'h1c) | dma_cfg_pkg::addr_t'(off * 4);
      fill_block(addr, 1'($urandom_range(0, 1)));
    end
    drain_and_check();

    test_name = "backpressure";
    stall_on  = 1'b1;
    for (int i = 0; i < 8; i++) begin
      addr = $urandom;
      way  = 1'($urandom_range(0, 1));
      fill_block(addr, way);
      evict_block(addr, way);
    end
    drain_and_check();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/dma_cfg_pkg.sv
design/dma_msg_pkg.sv
design/dma_word_counter.sv
design/dma_fill_fifo.sv
design/dma_evict_buffer.sv
design/cache_data_mem.sv
design/cache_dma_ctrl.sv
design/cache_dma_top.sv
test/cache_dma_tb.sv
